// File: dds_pkg.sv
package dds_pkg;

   ///////////////////////////////////////////////////////////////////////
   // sizes
   ///////////////////////////////////////////////////////////////////////
   localparam int SAMPLE_W   = 12;
   localparam int PHASE_W    = 32;
   localparam int LFSR_W     = 5;
   localparam int NUM_KEYS   = 17;
   localparam int QTAB_DEPTH = 32;
   localparam int AMP_MAX    = 2047;
   localparam int APB_ADDR_W = 5;
   localparam int APB_DATA_W = 32;

   ///////////////////////////////////////////////////////////////////////
   // register map, byte addresses
   ///////////////////////////////////////////////////////////////////////
   localparam logic [APB_ADDR_W-1:0] REG_CTRL      = 5'h00;  // en, wave sel, mod sel
   localparam logic [APB_ADDR_W-1:0] REG_PHASE_INC = 5'h04;
   localparam logic [APB_ADDR_W-1:0] REG_PHASE     = 5'h08;  // write loads accumulator
   localparam logic [APB_ADDR_W-1:0] REG_LFSR_DIV  = 5'h0C;
   localparam logic [APB_ADDR_W-1:0] REG_LFSR      = 5'h10;  // read only
   localparam logic [APB_ADDR_W-1:0] REG_KEYS      = 5'h14;  // read only

   // key k makes with KEY_MAKE_BASE + k, breaks with bit 7 added
   localparam logic [7:0] KEY_MAKE_BASE  = 8'h20;
   localparam logic [7:0] KEY_BREAK_FLAG = 8'h80;

   localparam logic [LFSR_W-1:0] LFSR_SEED = 5'b00001;
   localparam string QTAB_FILE = "sine_quarter.hex";

   ///////////////////////////////////////////////////////////////////////
   // types
   ///////////////////////////////////////////////////////////////////////
   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic [NUM_KEYS-1:0] key_vec_t;

   typedef enum logic [1:0]
   {
      SEL_SIN = 2'd0,
      SEL_COS = 2'd1,
      SEL_SQU = 2'd2,
      SEL_SAW = 2'd3
   } wave_sel_t;

   // code 3 is treated like MOD_NONE
   typedef enum logic [1:0]
   {
      MOD_NONE = 2'd0,
      MOD_ASK  = 2'd1,
      MOD_BPSK = 2'd2
   } mod_sel_t;

   typedef struct packed
   {
      logic [1:0]  quadrant;  // which quarter of the period
      logic [4:0]  index;     // quarter table address
      logic [24:0] frac;      // below table resolution
   } phase_fields_t;

   typedef union packed
   {
      logic [PHASE_W-1:0] raw;
      phase_fields_t      fields;
   } phase_word_u;

endpackage

// File: dds_ctrl_if.sv
`timescale 1ns/1ps

interface dds_ctrl_if;
   import dds_pkg::*;

   logic                  enable;
   wave_sel_t             wave_sel;
   mod_sel_t              mod_sel;
   logic [PHASE_W-1:0]    phase_inc;
   logic                  phase_load;        // single cycle strobe
   logic [PHASE_W-1:0]    phase_load_value;
   logic [APB_DATA_W-1:0] lfsr_div;
   logic [PHASE_W-1:0]    phase;             // live accumulator value
   logic [LFSR_W-1:0]     lfsr;

   modport regs_mp (
      output enable, wave_sel, mod_sel, phase_inc, phase_load, phase_load_value, lfsr_div,
      input  phase, lfsr
   );

   modport nco_mp (
      input  enable, phase_inc, phase_load, phase_load_value,
      output phase
   );

   modport mod_mp (
      input  enable, wave_sel, mod_sel, lfsr_div,
      output lfsr
   );

endinterface

// File: apb_regs.sv
`timescale 1ns/1ps

module apb_regs (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [dds_pkg::APB_ADDR_W-1:0]    paddr,
   input  logic [dds_pkg::APB_DATA_W-1:0]    pwdata,
   output logic [dds_pkg::APB_DATA_W-1:0]    prdata,
   output logic                              pready,
   output logic                              pslverr,
   input  dds_pkg::key_vec_t                 keys,
   dds_ctrl_if.regs_mp                       ctrl
);
   import dds_pkg::*;

   logic                  access;
   logic                  addr_hit;
   logic                  read_only;
   logic                  wr_en;
   logic [4:0]            ctrl_q;           // {mod_sel, wave_sel, enable}
   logic [PHASE_W-1:0]    phase_inc_q;
   logic [APB_DATA_W-1:0] lfsr_div_q;
   logic                  phase_load_q;
   logic [PHASE_W-1:0]    phase_load_value_q;
   logic [APB_DATA_W-1:0] rdata;

   assign access    = psel && penable;
   assign read_only = (paddr == REG_LFSR) || (paddr == REG_KEYS);
   assign wr_en     = access && pwrite && addr_hit && !read_only;

   ///////////////////////////////////////////////////////////////////////
   // writable registers
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ctrl_q       <= '0;
         phase_inc_q  <= '0;
         lfsr_div_q   <= '0;
         phase_load_q <= 1'b0;
      end
      else
      begin
         phase_load_q <= wr_en && (paddr == REG_PHASE);  // strobe after the access cycle
         if (wr_en && (paddr == REG_CTRL))
            ctrl_q <= pwdata[4:0];
         if (wr_en && (paddr == REG_PHASE_INC))
            phase_inc_q <= pwdata;
         if (wr_en && (paddr == REG_LFSR_DIV))
            lfsr_div_q <= pwdata;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en && (paddr == REG_PHASE))
         phase_load_value_q <= pwdata;
   end

   assign ctrl.enable           = ctrl_q[0];
   assign ctrl.wave_sel         = wave_sel_t'(ctrl_q[2:1]);
   assign ctrl.mod_sel          = mod_sel_t'(ctrl_q[4:3]);
   assign ctrl.phase_inc        = phase_inc_q;
   assign ctrl.lfsr_div         = lfsr_div_q;
   assign ctrl.phase_load       = phase_load_q;
   assign ctrl.phase_load_value = phase_load_value_q;

   ///////////////////////////////////////////////////////////////////////
   // read decode
   ///////////////////////////////////////////////////////////////////////
   always_comb
   begin
      addr_hit = 1'b1;
      rdata    = '0;
      case (paddr)
         REG_CTRL:      rdata = 32'(ctrl_q);
         REG_PHASE_INC: rdata = phase_inc_q;
         REG_PHASE:     rdata = ctrl.phase;
         REG_LFSR_DIV:  rdata = lfsr_div_q;
         REG_LFSR:      rdata = 32'(ctrl.lfsr);
         REG_KEYS:      rdata = 32'(keys);
         default:       addr_hit = 1'b0;
      endcase
   end

   assign prdata  = rdata;
   assign pready  = 1'b1;                                      // zero wait states
   assign pslverr = access && (!addr_hit || (pwrite && read_only));

   // every access phase has to follow a setup phase
   penable_after_setup: assert property (
      @(posedge clk) disable iff (rst) $rose(penable) |-> psel && $past(psel)
   );

endmodule

// File: scan_key_tracker.sv
`timescale 1ns/1ps

module scan_key_tracker (
   input  logic              clk,
   input  logic              rst,
   input  logic              scan_event_ready,
   input  logic [7:0]        scan_event_code,
   output dds_pkg::key_vec_t keys
);
   import dds_pkg::*;

   logic [6:0] key_offset;
   logic       key_hit;
   logic       is_break;
   key_vec_t   keys_q;

   // codes below the base wrap to large offsets and miss
   assign key_offset = scan_event_code[6:0] - KEY_MAKE_BASE[6:0];
   assign key_hit    = key_offset < NUM_KEYS;
   assign is_break   = |(scan_event_code & KEY_BREAK_FLAG);

   always_ff @(posedge clk)
   begin
      if (rst)
         keys_q <= '0;
      else if (scan_event_ready && key_hit)
         keys_q[key_offset[4:0]] <= !is_break;  // make sets, break clears
   end

   assign keys = keys_q;

endmodule

// File: nco_waveform.sv
`timescale 1ns/1ps

module nco_waveform (
   input  logic             clk,
   input  logic             rst,
   dds_ctrl_if.nco_mp       ctrl,
   output dds_pkg::sample_t sin_out,
   output dds_pkg::sample_t cos_out,
   output dds_pkg::sample_t squ_out,
   output dds_pkg::sample_t saw_out
);
   import dds_pkg::*;

   phase_word_u         phase_q;
   phase_word_u         cos_phase;
   logic [SAMPLE_W-1:0] qtab [QTAB_DEPTH];  // first quarter magnitudes
   sample_t             sin_q;
   sample_t             cos_q;
   sample_t             squ_q;
   sample_t             saw_q;

   initial
   begin
      $readmemh(QTAB_FILE, qtab);
   end

   ///////////////////////////////////////////////////////////////////////
   // phase accumulator
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rst)
         phase_q.raw <= '0;
      else if (ctrl.phase_load)
         phase_q.raw <= ctrl.phase_load_value;   // load beats the increment
      else if (ctrl.enable)
         phase_q.raw <= phase_q.raw + ctrl.phase_inc;
   end

   assign ctrl.phase = phase_q.raw;

   // cosine leads by a quarter turn
   assign cos_phase.raw = phase_q.raw + (PHASE_W'(1) << (PHASE_W - 2));

   // odd quadrants walk the table backwards, upper half is negated
   function automatic sample_t quarter_lookup(input phase_word_u p);
      logic [4:0] idx;
      sample_t    mag;
      begin
         if (p.fields.quadrant[0])
            idx = 5'(QTAB_DEPTH - 1) - p.fields.index;
         else
            idx = p.fields.index;
         mag = sample_t'(qtab[idx]);
         return p.fields.quadrant[1] ? -mag : mag;
      end
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // registered waveforms
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      sin_q <= quarter_lookup(phase_q);
      cos_q <= quarter_lookup(cos_phase);
      if (phase_q.fields.quadrant[1])
         squ_q <= sample_t'(-AMP_MAX);
      else
         squ_q <= sample_t'(AMP_MAX);
      saw_q <= sample_t'(phase_q.raw[PHASE_W-1 -: SAMPLE_W]);  // top bits as signed ramp
   end

   assign sin_out = sin_q;
   assign cos_out = cos_q;
   assign squ_out = squ_q;
   assign saw_out = saw_q;

endmodule

// File: prbs_modulator.sv
`timescale 1ns/1ps

module prbs_modulator (
   input  logic             clk,
   input  logic             rst,
   dds_ctrl_if.mod_mp       ctrl,
   input  dds_pkg::sample_t sin_in,
   input  dds_pkg::sample_t cos_in,
   input  dds_pkg::sample_t squ_in,
   input  dds_pkg::sample_t saw_in,
   output dds_pkg::sample_t wave_out,
   output dds_pkg::sample_t mod_out
);
   import dds_pkg::*;

   logic [APB_DATA_W-1:0] tick_cnt;
   logic                  tick;
   logic [LFSR_W-1:0]     lfsr_q;
   sample_t               wave_mux;
   sample_t               mod_mux;
   sample_t               wave_q;
   sample_t               mod_q;

   ///////////////////////////////////////////////////////////////////////
   // tick divider and LFSR
   ///////////////////////////////////////////////////////////////////////
   assign tick = tick_cnt >= ctrl.lfsr_div;  // also recovers if the divider shrinks

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         tick_cnt <= '0;
         lfsr_q   <= LFSR_SEED;
      end
      else if (ctrl.enable)
      begin
         if (tick)
         begin
            tick_cnt <= '0;
            lfsr_q   <= {lfsr_q[3:0], lfsr_q[4] ^ lfsr_q[2]};  // x^5 + x^3 + 1
         end
         else
            tick_cnt <= tick_cnt + 1'b1;
      end
   end

   assign ctrl.lfsr = lfsr_q;

   ///////////////////////////////////////////////////////////////////////
   // waveform and modulation select
   ///////////////////////////////////////////////////////////////////////
   always_comb
   begin
      case (ctrl.wave_sel)
         SEL_SIN: wave_mux = sin_in;
         SEL_COS: wave_mux = cos_in;
         SEL_SQU: wave_mux = squ_in;
         default: wave_mux = saw_in;
      endcase
      case (ctrl.mod_sel)
         MOD_ASK:  mod_mux = lfsr_q[0] ? cos_in : '0;      // on/off keying
         MOD_BPSK: mod_mux = lfsr_q[0] ? cos_in : -cos_in;
         default:  mod_mux = wave_mux;                     // includes code 3
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wave_q <= '0;
         mod_q  <= '0;
      end
      else
      begin
         wave_q <= wave_mux;
         mod_q  <= mod_mux;
      end
   end

   assign wave_out = wave_q;
   assign mod_out  = mod_q;

   // all-zero state would lock the sequence
   lfsr_not_zero: assert property (
      @(posedge clk) disable iff (rst) lfsr_q != '0
   );

endmodule

// File: dds_modulator_top.sv
`timescale 1ns/1ps

module dds_modulator_top (
   input  logic                           CLK_25MHZ,
   input  logic                           reset_from_key,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [dds_pkg::APB_ADDR_W-1:0] paddr,
   input  logic [dds_pkg::APB_DATA_W-1:0] pwdata,
   output logic [dds_pkg::APB_DATA_W-1:0] prdata,
   output logic                           pready,
   output logic                           pslverr,
   input  logic                           scan_event_ready,
   input  logic [7:0]                     scan_event_code,
   output dds_pkg::sample_t               wave_out,
   output dds_pkg::sample_t               mod_out
);
   import dds_pkg::*;

   key_vec_t keys;
   sample_t  sin_w;
   sample_t  cos_w;
   sample_t  squ_w;
   sample_t  saw_w;

   dds_ctrl_if ctrl_if ();

   ///////////////////////////////////////////////////////////////////////
   // control path
   ///////////////////////////////////////////////////////////////////////
   apb_regs apb_regs_inst (
      .clk     (CLK_25MHZ),
      .rst     (reset_from_key),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .keys    (keys),
      .ctrl    (ctrl_if.regs_mp)
   );

   scan_key_tracker scan_key_tracker_inst (
      .clk              (CLK_25MHZ),
      .rst              (reset_from_key),
      .scan_event_ready (scan_event_ready),
      .scan_event_code  (scan_event_code),
      .keys             (keys)
   );

   ///////////////////////////////////////////////////////////////////////
   // signal path
   ///////////////////////////////////////////////////////////////////////
   nco_waveform nco_waveform_inst (
      .clk     (CLK_25MHZ),
      .rst     (reset_from_key),
      .ctrl    (ctrl_if.nco_mp),
      .sin_out (sin_w),
      .cos_out (cos_w),
      .squ_out (squ_w),
      .saw_out (saw_w)
   );

   prbs_modulator prbs_modulator_inst (
      .clk      (CLK_25MHZ),
      .rst      (reset_from_key),
      .ctrl     (ctrl_if.mod_mp),
      .sin_in   (sin_w),
      .cos_in   (cos_w),
      .squ_in   (squ_w),
      .saw_in   (saw_w),
      .wave_out (wave_out),
      .mod_out  (mod_out)
   );

endmodule

// File: tb_dds_modulator.sv
`timescale 1ns/1ps

module tb_dds_modulator;
   import dds_pkg::*;

   localparam int CLK_HALF   = 20;     // 40 ns period
   localparam int NUM_ROWS   = 36;
   localparam int NUM_KEY_EV = 12;
   localparam int APB_WAIT   = 16;
   localparam int MAX_CYCLES = 50000;

   logic                  CLK_25MHZ;
   logic                  reset_from_key;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [APB_ADDR_W-1:0] paddr;
   logic [APB_DATA_W-1:0] pwdata;
   logic [APB_DATA_W-1:0] prdata;
   logic                  pready;
   logic                  pslverr;
   logic                  scan_event_ready;
   logic [7:0]            scan_event_code;
   sample_t               wave_out;
   sample_t               mod_out;

   logic [SAMPLE_W-1:0] qtab_ref [QTAB_DEPTH];  // reference copy of the sine table
   int                  error_count;

   ///////////////////////////////////////////////////////////////////////
   // stimulus tables
   ///////////////////////////////////////////////////////////////////////
   string       row_name   [NUM_ROWS];
   logic [31:0] row_phase  [NUM_ROWS];
   wave_sel_t   row_wave   [NUM_ROWS];
   logic [1:0]  row_mod    [NUM_ROWS];
   logic        row_on_mod [NUM_ROWS];  // check mod_out instead of wave_out

   // quadrant boundaries and the phases just below them
   logic [31:0] edge_phase [6] = '{32'h0000_0000, 32'h3FFF_FFFF, 32'h4000_0000,
                                   32'h8000_0000, 32'hBFFF_FFFF, 32'hC000_0000};

   logic [7:0] key_code   [NUM_KEY_EV] = '{8'h20, 8'h25, 8'h30, 8'h31, 8'h1F, 8'hA5,
                                           8'h05, 8'h2B, 8'hB0, 8'h2A, 8'hA0, 8'hFF};
   logic       key_ready  [NUM_KEY_EV] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
                                           1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
   key_vec_t   key_expect [NUM_KEY_EV] = '{17'h00001, 17'h00021, 17'h10021, 17'h10021,
                                           17'h10021, 17'h10001, 17'h10001, 17'h10001,
                                           17'h00001, 17'h00401, 17'h00400, 17'h00400};

   dds_modulator_top dds_modulator_top_inst (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .prdata           (prdata),
      .pready           (pready),
      .pslverr          (pslverr),
      .scan_event_ready (scan_event_ready),
      .scan_event_code  (scan_event_code),
      .wave_out         (wave_out),
      .mod_out          (mod_out)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #CLK_HALF CLK_25MHZ = ~CLK_25MHZ;
   end

   ///////////////////////////////////////////////////////////////////////
   // error handling and compare tasks
   ///////////////////////////////////////////////////////////////////////
   task automatic fail_run();
      begin
         error_count++;
         $display("Errors found");
         $fatal(1, "stopped at the first error");
      end
   endtask

   task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
      begin
         if (actual !== expected)
         begin
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
            fail_run();
         end
      end
   endtask

   task automatic check_keys(input string name, input key_vec_t expected, input key_vec_t actual);
      begin
         if (actual !== expected)
         begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            fail_run();
         end
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      begin
         if (actual !== expected)
         begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            fail_run();
         end
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      begin
         if (actual !== expected)
         begin
            $display("FAIL %s expected %b actual %b", name, expected, actual);
            fail_run();
         end
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // APB driver
   ///////////////////////////////////////////////////////////////////////
   task automatic apb_transfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      int waited;
      begin
         waited = 0;
         @(posedge CLK_25MHZ);
         #2;
         psel   = 1'b1;                 // setup cycle
         pwrite = write;
         paddr  = addr;
         pwdata = wdata;
         @(posedge CLK_25MHZ);
         #2;
         penable = 1'b1;                // access cycle
         #1;
         while (pready !== 1'b1)
         begin
            @(posedge CLK_25MHZ);
            #3;
            waited++;
            if (waited > APB_WAIT)
            begin
               $display("APB transfer to address %h never got pready", addr);
               fail_run();
            end
         end
         rdata = prdata;
         err   = pslverr;
         @(posedge CLK_25MHZ);
         #2;
         psel    = 1'b0;
         penable = 1'b0;
         pwrite  = 1'b0;
      end
   endtask

   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic err);
      logic [31:0] unused_rd;
      begin
         apb_transfer(1'b1, addr, data, unused_rd, err);
      end
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic err);
      begin
         apb_transfer(1'b0, addr, 32'h0, data, err);
      end
   endtask

   task automatic write_reg(input string name, input logic [APB_ADDR_W-1:0] addr,
                            input logic [31:0] data);
      logic err;
      begin
         apb_write(addr, data, err);
         check_bit({name, " pslverr"}, 1'b0, err);
      end
   endtask

   task automatic read_reg(input string name, input logic [APB_ADDR_W-1:0] addr,
                           output logic [31:0] data);
      logic err;
      begin
         apb_read(addr, data, err);
         check_bit({name, " pslverr"}, 1'b0, err);
      end
   endtask

   task automatic idle_cycles(input int n);
      begin
         repeat (n) @(posedge CLK_25MHZ);
         #2;
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // reference models
   ///////////////////////////////////////////////////////////////////////
   function automatic sample_t sine_ref(input logic [31:0] ph);
      logic [4:0] pos;
      sample_t    val;
      begin
         pos = ph[29:25];
         case (ph[31:30])
            2'd0:    val = sample_t'(qtab_ref[pos]);
            2'd1:    val = sample_t'(qtab_ref[5'd31 - pos]);   // falling half of the hump
            2'd2:    val = -sample_t'(qtab_ref[pos]);
            default: val = -sample_t'(qtab_ref[5'd31 - pos]);
         endcase
         return val;
      end
   endfunction

   function automatic sample_t wave_ref(input logic [31:0] ph, input wave_sel_t sel);
      begin
         case (sel)
            SEL_SIN: return sine_ref(ph);
            SEL_COS: return sine_ref(ph + 32'h4000_0000);
            SEL_SQU: return ph[31] ? sample_t'(-AMP_MAX) : sample_t'(AMP_MAX);
            default: return sample_t'(ph[31:20]);
         endcase
      end
   endfunction

   function automatic sample_t mod_ref(input logic [31:0] ph, input wave_sel_t sel,
                                       input logic [1:0] msel, input logic data_bit);
      sample_t carrier;
      begin
         carrier = sine_ref(ph + 32'h4000_0000);
         case (msel)
            MOD_ASK:  return data_bit ? carrier : sample_t'(0);
            MOD_BPSK: return data_bit ? carrier : -carrier;
            default:  return wave_ref(ph, sel);     // code 3 as well
         endcase
      end
   endfunction

   task automatic build_rows();
      int r;
      begin
         r = 0;
         for (int s = 0; s < 4; s++)
         begin
            for (int e = 0; e < 7; e++)
            begin
               row_phase[r]  = (e < 6) ? edge_phase[e] : $urandom;
               row_wave[r]   = wave_sel_t'(2'(s));
               row_mod[r]    = MOD_NONE;
               row_on_mod[r] = 1'b0;
               row_name[r]   = $sformatf("wave sel %0d phase %h", s, row_phase[r]);
               r++;
            end
         end
         for (int m = 0; m < 8; m++)
         begin
            row_phase[r]  = $urandom;
            row_wave[r]   = wave_sel_t'(2'(m + 1));
            row_mod[r]    = 2'(m % 4);
            row_on_mod[r] = 1'b1;
            row_name[r]   = $sformatf("mod sel %0d phase %h", m % 4, row_phase[r]);
            r++;
         end
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // test sequences
   ///////////////////////////////////////////////////////////////////////
   task automatic apply_row(input int i);
      logic [31:0] rd;
      begin
         if (row_on_mod[i])
         begin
            write_reg(row_name[i], REG_CTRL, 32'h1);   // a few LFSR steps between rows
            write_reg(row_name[i], REG_CTRL, 32'h0);
         end
         read_reg(row_name[i], REG_LFSR, rd);
         write_reg(row_name[i], REG_CTRL, {27'd0, row_mod[i], row_wave[i], 1'b0});
         write_reg(row_name[i], REG_PHASE, row_phase[i]);
         idle_cycles(4);                           // load to output latency
         if (row_on_mod[i])
            check_sample(row_name[i], mod_ref(row_phase[i], row_wave[i], row_mod[i], rd[0]),
                         mod_out);
         else
            check_sample(row_name[i], wave_ref(row_phase[i], row_wave[i]), wave_out);
      end
   endtask

   task automatic lfsr_sequence();
      logic [31:0]       rd;
      logic [LFSR_W-1:0] prev;
      logic [LFSR_W-1:0] next_val;
      int                polls;
      begin
         write_reg("lfsr div", REG_LFSR_DIV, 32'd50);
         read_reg("lfsr seed", REG_LFSR, rd);
         check_word("lfsr seed", 32'(LFSR_SEED), rd);
         write_reg("lfsr enable", REG_CTRL, 32'h1);
         prev = LFSR_SEED;
         for (int step = 1; step <= 20; step++)
         begin
            next_val = {prev[3:0], prev[4] ^ prev[2]};   // x^5 + x^3 + 1
            polls    = 0;
            rd       = 32'(prev);
            while (rd == 32'(prev))
            begin
               polls++;
               if (polls > 100)
               begin
                  $display("LFSR did not step within 100 register reads");
                  fail_run();
               end
               read_reg("lfsr poll", REG_LFSR, rd);
            end
            check_word($sformatf("lfsr step %0d", step), 32'(next_val), rd);
            prev = rd[LFSR_W-1:0];
         end
         write_reg("lfsr disable", REG_CTRL, 32'h0);
      end
   endtask

   task automatic phase_accumulation();
      logic [31:0] start;
      logic [31:0] inc;
      logic [31:0] rd;
      logic        found;
      string       name;
      begin
         for (int s = 0; s < 4; s++)
         begin
            name  = $sformatf("accumulate sel %0d", s);
            start = $urandom;
            inc   = $urandom | 32'h1;
            write_reg(name, REG_PHASE, start);
            write_reg(name, REG_PHASE_INC, inc);
            write_reg(name, REG_CTRL, {27'd0, 2'b00, 2'(s), 1'b1});
            write_reg(name, REG_CTRL, {27'd0, 2'b00, 2'(s), 1'b0});
            read_reg(name, REG_PHASE, rd);
            found = 1'b0;
            for (int k = 1; k <= 64; k++)
               if (start + 32'(k) * inc == rd)
                  found = 1'b1;
            if (!found)
            begin
               $display("%s phase %h is not %h plus whole steps of %h", name, rd, start, inc);
               fail_run();
            end
            idle_cycles(4);
            check_sample(name, wave_ref(rd, wave_sel_t'(2'(s))), wave_out);
         end
      end
   endtask

   task automatic key_tracking();
      logic [31:0] rd;
      string       name;
      begin
         for (int i = 0; i < NUM_KEY_EV; i++)
         begin
            name = $sformatf("key event %0d code %h", i, key_code[i]);
            @(posedge CLK_25MHZ);
            #2;
            scan_event_ready = key_ready[i];
            scan_event_code  = key_code[i];
            @(posedge CLK_25MHZ);
            #2;
            scan_event_ready = 1'b0;
            scan_event_code  = 8'h00;
            read_reg(name, REG_KEYS, rd);
            check_keys(name, key_expect[i], rd[NUM_KEYS-1:0]);
         end
      end
   endtask

   // overall cycle limit
   initial
   begin
      for (int c = 0; c < MAX_CYCLES; c++)
         @(posedge CLK_25MHZ);
      $display("simulation ran past %0d cycles without finishing", MAX_CYCLES);
      fail_run();
   end

   ///////////////////////////////////////////////////////////////////////
   // main sequence
   ///////////////////////////////////////////////////////////////////////
   initial
   begin
      logic [31:0] rd;
      logic        err;

      error_count      = 0;
      reset_from_key   = 1'b1;
      psel             = 1'b0;
      penable          = 1'b0;
      pwrite           = 1'b0;
      paddr            = '0;
      pwdata           = '0;
      scan_event_ready = 1'b0;
      scan_event_code  = 8'h00;
      void'($urandom(32'h68bf));
      $readmemh("sine_quarter.hex", qtab_ref);
      build_rows();
      repeat (10) @(posedge CLK_25MHZ);
      #2;
      reset_from_key = 1'b0;

      // register access
      write_reg("ctrl write", REG_CTRL, 32'h0000_001A);
      read_reg("ctrl read", REG_CTRL, rd);
      check_word("ctrl readback", 32'h0000_001A, rd);
      write_reg("phase_inc write", REG_PHASE_INC, 32'hA5C3_0F17);
      read_reg("phase_inc read", REG_PHASE_INC, rd);
      check_word("phase_inc readback", 32'hA5C3_0F17, rd);
      write_reg("lfsr_div write", REG_LFSR_DIV, 32'h0000_1234);
      read_reg("lfsr_div read", REG_LFSR_DIV, rd);
      check_word("lfsr_div readback", 32'h0000_1234, rd);
      apb_read(5'h18, rd, err);
      check_bit("unmapped read 0x18", 1'b1, err);
      apb_read(5'h02, rd, err);
      check_bit("unmapped read 0x02", 1'b1, err);
      apb_write(REG_KEYS, 32'h0001_FFFF, err);
      check_bit("keys write", 1'b1, err);
      read_reg("keys after write", REG_KEYS, rd);
      check_keys("keys after write", '0, rd[NUM_KEYS-1:0]);
      apb_write(REG_LFSR, 32'h0000_001F, err);
      check_bit("lfsr write", 1'b1, err);

      lfsr_sequence();

      // one LFSR step per enabled cycle for the modulation rows
      write_reg("lfsr div zero", REG_LFSR_DIV, 32'd0);

      // waveform and modulation rows
      for (int i = 0; i < NUM_ROWS; i++)
         apply_row(i);

      phase_accumulation();
      key_tracking();

      if (error_count == 0)
      begin
         $display("No errors");
         $finish;
      end
      else
      begin
         $display("Errors found");
         $fatal(1, "run ended with errors");
      end
   end

endmodule

// File: sine_quarter.hex
// one column: first quarter sine magnitude, 12-bit hex, entry i at angle (i+0.5)*pi/64
// full scale is 2047, 32 entries from index 0 up to index 31
032
097
0FB
15E
1C0
222
282
2E1
33E
398
3F1
447
49B
4EB
539
583
5CB
60E
64E
68A
6C1
6F5
724
74F
776
798
7B5
7CD
7E1
7F0
7F9
7FE

// File: tb.f
dds_pkg.sv
dds_ctrl_if.sv
apb_regs.sv
scan_key_tracker.sv
nco_waveform.sv
prbs_modulator.sv
dds_modulator_top.sv
tb_dds_modulator.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_dds_modulator -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^No errors$" "$LOG"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi
